// File: sim.f
logic/uartPkg.sv
logic/baudGen.sv
logic/uartRx.sv
logic/uartTx.sv
logic/charFifo.sv
logic/rxCreditGate.sv
logic/uartCore.sv
tb/uartTb.sv

// File: run.sh
#!/bin/sh
# Build and run the UART testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module uartTb -o uartSim

./obj_dir/uartSim | tee sim.log

# Result decided by the log
grep -q "TEST RESULT: PASS" sim.log

// File: tb/uartTb.sv
////////////////////////////////////////////////////////////
// UART testbench
//   Clock, reset, loopback or bit-banged serial line
//   Xorshift stimulus, reference queue, checking assertions
////////////////////////////////////////////////////////////

module uartTb
   import uartPkg::*;
;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLKS_PER_BIT = 64;
   localparam int DRAIN_LIMIT  = 20000;
   localparam int TX_DEPTH     = 4;

   logic    clk = 1'b0;
   logic    rst = 1'b1;
   logic    clr = 1'b0;
   charLenT len = len8;
   parityT  parity = parNone;
   stopT    stop = stop1;
   logic    rxd;
   logic    txd;
   logic    txValid = 1'b0;
   txCharT  txData = '0;
   logic    txCredit;
   logic    rxValid;
   txCharT  rxData;
   logic    rxPare;
   logic    rxFrme;
   logic    rxOvre;
   logic    rxCredit = 1'b0;

   // High selects the loopback line
   logic        lineSel = 1'b1;
   logic        bangLine = 1'b1;
   logic        txQuiet = 1'b0;
   logic        autoCredit = 1'b1;
   logic        prevCredit = 1'b0;
   logic [31:0] rngState = 32'd93178;
   logic [10:0] expQ [$];
   logic [10:0] expHead;
   int          checkIdx = 0;
   int          gateCredits = 2;
   int          returnedCount = 0;
   int          sentCount = 0;
   int          txCreditCount = 0;
   int          deliveredCount = 0;
   int          checkErrors = 0;
   int          stepErrors = 0;
   int          passCount = 0;
   int          failCount = 0;
   int          errBefore;
   int          mark;

   assign rxd = lineSel ? txd : bangLine;

   always #20 clk = ~clk;

   uartCore #(
      .CLKS_PER_TICK (4),
      .TX_DEPTH      (TX_DEPTH),
      .RX_DEPTH      (4),
      .RX_CREDITS    (2)
   ) uartCore_inst
   (
      .clk      (clk),
      .rst      (rst),
      .clr      (clr),
      .len      (len),
      .parity   (parity),
      .stop     (stop),
      .rxd      (rxd),
      .txd      (txd),
      .txValid  (txValid),
      .txData   (txData),
      .txCredit (txCredit),
      .rxValid  (rxValid),
      .rxData   (rxData),
      .rxPare   (rxPare),
      .rxFrme   (rxFrme),
      .rxOvre   (rxOvre),
      .rxCredit (rxCredit)
   );

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   function automatic logic [31:0] nextRand();
      logic [31:0] x;
      x = rngState;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rngState = x;
      return x;
   endfunction

   // Data, pare, frme, ovre from high to low
   function automatic logic [10:0] mkEntry(logic [7:0] d, logic p, logic f, logic o);
      return {d, p, f, o};
   endfunction

   // One bit set for each of the 5 plus code data bits
   function automatic logic [7:0] lenMask(charLenT l);
      logic [7:0] m;
      m = '0;
      for (int i = 0; i < 5 + int'(l); i++)
         m[i] = 1'b1;
      return m;
   endfunction

   function automatic int errorTotal();
      return checkErrors + stepErrors;
   endfunction

   task automatic abortOnTimeout(input string what);
      $display("Timeout while waiting for %s at %0t", what, $time);
      $display("TEST RESULT: FAIL");
      $finish;
   endtask

   task automatic setFormat(input charLenT l, input parityT p, input stopT s);
      @(negedge clk);
      len    = l;
      parity = p;
      stop   = s;
   endtask

   // Producer never sends without credit
   task automatic sendChar(input logic [7:0] c);
      int n;
      n = 0;
      while (TX_DEPTH - sentCount + txCreditCount == 0)
      begin
         @(negedge clk);
         n++;
         if (n > DRAIN_LIMIT)
            abortOnTimeout("a transmit credit");
      end
      @(negedge clk);
      txValid = 1'b1;
      txData  = c;
      sentCount++;
      @(negedge clk);
      txValid = 1'b0;
   endtask

   // Loopback character with clean flags expected
   task automatic sendLoop(input logic [7:0] c);
      expQ.push_back(mkEntry(c & lenMask(len), 1'b0, 1'b0, 1'b0));
      sendChar(c);
   endtask

   task automatic waitDrained();
      int n;
      n = 0;
      while (checkIdx != expQ.size())
      begin
         @(negedge clk);
         n++;
         if (n > DRAIN_LIMIT)
            abortOnTimeout("expected receive entries");
      end
   endtask

   // Both lines high for a stretch
   task automatic waitIdle(input int quiet);
      int n;
      int run;
      n   = 0;
      run = 0;
      while (run < quiet)
      begin
         @(negedge clk);
         run = (txd && rxd) ? run + 1 : 0;
         n++;
         if (n > DRAIN_LIMIT)
            abortOnTimeout("an idle serial line");
      end
   endtask

   task automatic holdBit(input logic b);
      bangLine = b;
      repeat (CLKS_PER_BIT) @(negedge clk);
   endtask

   // One frame on the bit-banged line with optional faults
   task automatic bangFrame(input logic [7:0] d, input logic flipPar,
                            input logic lowStop1, input logic lowStop2);
      int  nBits;
      logic pb;
      nBits = 5 + int'(len);
      pb    = ^(d & lenMask(len));
      if (parity == parOdd)
         pb = ~pb;
      @(negedge clk);
      holdBit(1'b0);
      for (int i = 0; i < nBits; i++)
         holdBit(d[i]);
      if (parity == parEven || parity == parOdd)
         holdBit(pb ^ flipPar);
      holdBit(~lowStop1);
      if (stop == stop2)
         holdBit(~lowStop2);
      holdBit(1'b1);
      holdBit(1'b1);
   endtask

   task automatic endTest(input int num, input string name);
      if (errorTotal() == errBefore)
      begin
         passCount++;
         $display("test %0d %s passed", num, name);
      end
      else
      begin
         failCount++;
         $display("test %0d %s failed with %0d errors", num, name,
                  errorTotal() - errBefore);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Checking
   ////////////////////////////////////////////////////////////

   // Registered outputs are settled at the rising edge
   always @(posedge clk)
   begin
      if (!rst)
      begin
         if (txCredit)
            txCreditCount++;
         if (rxValid)
         begin
            deliveredCount++;
            assert (gateCredits > 0)
            else
            begin
               $display("rxValid rose at %0t with no consumer credit", $time);
               checkErrors++;
            end
            if (checkIdx >= expQ.size())
            begin
               $display("Unexpected entry at %0t with data %h", $time, rxData);
               checkErrors++;
            end
            else
            begin
               expHead = expQ[checkIdx];
               checkIdx++;
               assert ({rxData, rxPare, rxFrme, rxOvre} == expHead)
               else
               begin
                  $display(
                     "Mismatch at %0t: got data %h pare %b frme %b ovre %b, want %h %b %b %b",
                     $time, rxData, rxPare, rxFrme, rxOvre,
                     expHead[10:3], expHead[2], expHead[1], expHead[0]);
                  checkErrors++;
               end
            end
         end
         // Credit seen at this edge counts from the next
         gateCredits = gateCredits - int'(rxValid) + int'(prevCredit);
         prevCredit  = rxCredit;
         if (txQuiet)
         begin
            assert (txd)
            else
            begin
               $display("txd low at %0t with no frame being sent", $time);
               checkErrors++;
            end
         end
      end
   end

   // Consumer returns one credit per delivery while enabled
   always @(negedge clk)
   begin
      if (autoCredit && deliveredCount > returnedCount)
      begin
         rxCredit = 1'b1;
         returnedCount++;
      end
      else
         rxCredit = 1'b0;
   end

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   initial
   begin
      repeat (2) @(negedge clk);
      rst = 1'b0;

      // 1 Loopback 8N1
      errBefore = errorTotal();
      mark      = txCreditCount;
      for (int i = 0; i < 8; i++)
         sendLoop(8'(nextRand()));
      waitDrained();
      waitIdle(100);
      assert (txCreditCount - mark == 8)
      else
      begin
         $display("Mismatch at %0t: expected 8 transmit credits, saw %0d",
                  $time, txCreditCount - mark);
         stepErrors++;
      end
      endTest(1, "loopback 8N1");

      // 2 Format sweep
      errBefore = errorTotal();
      for (int l = 0; l < 4; l++)
      begin
         setFormat(charLenT'(l), parEven, stop1);
         sendLoop(8'(nextRand()));
         waitDrained();
         waitIdle(100);
         setFormat(charLenT'(l), parOdd, stop1);
         sendLoop(8'(nextRand()));
         waitDrained();
         waitIdle(100);
         setFormat(charLenT'(l), parNone, stop2);
         sendLoop(8'(nextRand()));
         waitDrained();
         waitIdle(100);
      end
      endTest(2, "format sweep");

      // 3 Parity faults on the bit-banged line
      errBefore = errorTotal();
      lineSel   = 1'b0;
      txQuiet   = 1'b1;
      setFormat(len8, parEven, stop1);
      expQ.push_back(mkEntry(8'hA7, 1'b1, 1'b0, 1'b0));
      bangFrame(8'hA7, 1'b1, 1'b0, 1'b0);
      waitDrained();
      expQ.push_back(mkEntry(8'h3C, 1'b0, 1'b0, 1'b0));
      bangFrame(8'h3C, 1'b0, 1'b0, 1'b0);
      waitDrained();
      endTest(3, "parity error");

      // 4 Framing faults
      errBefore = errorTotal();
      setFormat(len8, parNone, stop1);
      expQ.push_back(mkEntry(8'h5A, 1'b0, 1'b1, 1'b0));
      bangFrame(8'h5A, 1'b0, 1'b1, 1'b0);
      waitDrained();
      setFormat(len7, parNone, stop2);
      expQ.push_back(mkEntry(8'h35, 1'b0, 1'b1, 1'b0));
      bangFrame(8'h35, 1'b0, 1'b0, 1'b1);
      waitDrained();
      endTest(4, "framing error");

      // 5 Back-pressure and overrun
      errBefore = errorTotal();
      txQuiet   = 1'b0;
      lineSel   = 1'b1;
      setFormat(len8, parNone, stop1);
      waitIdle(100);
      autoCredit = 1'b0;
      mark       = deliveredCount;
      for (int i = 0; i < 7; i++)
      begin
         if (i < 6)
            sendLoop(8'h40 + 8'(i));
         else
            sendChar(8'h46);
      end
      waitIdle(200);
      assert (deliveredCount - mark == 2 && expQ.size() - checkIdx == 4)
      else
      begin
         $display("Mismatch at %0t: back-pressure delivered %0d with %0d still expected",
                  $time, deliveredCount - mark, expQ.size() - checkIdx);
         stepErrors++;
      end
      autoCredit = 1'b1;
      waitDrained();
      expQ.push_back(mkEntry(8'h47, 1'b0, 1'b0, 1'b1));
      sendChar(8'h47);
      waitDrained();
      waitIdle(100);
      endTest(5, "credit back-pressure");

      // 6 Short start pulse, then clr mid-frame
      errBefore = errorTotal();
      lineSel   = 1'b0;
      txQuiet   = 1'b1;
      @(negedge clk);
      bangLine = 1'b0;
      repeat (12) @(negedge clk);
      bangLine = 1'b1;
      repeat (4 * CLKS_PER_BIT) @(negedge clk);
      expQ.push_back(mkEntry(8'h96, 1'b0, 1'b0, 1'b0));
      bangFrame(8'h96, 1'b0, 1'b0, 1'b0);
      waitDrained();
      // Upper data bits high so the line stays idle after clr
      fork
         bangFrame(8'hF0, 1'b0, 1'b0, 1'b0);
         begin
            repeat (5 * CLKS_PER_BIT + 32) @(negedge clk);
            clr = 1'b1;
            @(negedge clk);
            clr = 1'b0;
         end
      join
      expQ.push_back(mkEntry(8'h69, 1'b0, 1'b0, 1'b0));
      bangFrame(8'h69, 1'b0, 1'b0, 1'b0);
      waitDrained();
      endTest(6, "glitch and clear");

      $display("tests passed %0d failed %0d", passCount, failCount);
      if (errorTotal() == 0 && failCount == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// File: logic/uartCore.sv
////////////////////////////////////////////////////////////
// UART top level
//   Baud generator, receiver, transmitter, two FIFOs
//   Credit gate toward the consumer
////////////////////////////////////////////////////////////

module uartCore
   import uartPkg::*;
#(
   parameter int CLKS_PER_TICK = 4,
   parameter int TX_DEPTH      = 4,
   parameter int RX_DEPTH      = 4,
   parameter int RX_CREDITS    = 2
)
(
   input  logic    clk,
   input  logic    rst,
   input  logic    clr,
   input  charLenT len,
   input  parityT  parity,
   input  stopT    stop,
   input  logic    rxd,
   output logic    txd,
   input  logic    txValid,
   input  txCharT  txData,
   output logic    txCredit,
   output logic    rxValid,
   output txCharT  rxData,
   output logic    rxPare,
   output logic    rxFrme,
   output logic    rxOvre,
   input  logic    rxCredit
);

   logic    tick;
   logic    rxPush;
   rxEntryT rxEntry;
   logic    rxFull;
   logic    rxEmpty;
   logic    rxPop;
   rxEntryT rxHead;
   logic    txEmpty;
   logic    txPop;
   txCharT  txHead;

   // Shared 16x time base
   baudGen #(.CLKS_PER_TICK(CLKS_PER_TICK)) baudGen_inst
   (
      .clk  (clk),
      .rst  (rst),
      .tick (tick)
   );

   ////////////////////////////////////////////////////////////
   // Receive path
   ////////////////////////////////////////////////////////////

   uartRx uartRx_inst
   (
      .clk     (clk),
      .rst     (rst),
      .clr     (clr),
      .tick    (tick),
      .rxd     (rxd),
      .len     (len),
      .parity  (parity),
      .stop    (stop),
      .bufFull (rxFull),
      .push    (rxPush),
      .entry   (rxEntry)
   );

   // Credit output unused, the gate counts its own
   charFifo #(.T(rxEntryT), .DEPTH(RX_DEPTH)) rxFifo_inst
   (
      .clk      (clk),
      .rst      (rst),
      .push     (rxPush),
      .pushData (rxEntry),
      .pop      (rxPop),
      .head     (rxHead),
      .empty    (rxEmpty),
      .full     (rxFull),
      .credit   ()
   );

   rxCreditGate #(.RX_CREDITS(RX_CREDITS)) rxCreditGate_inst
   (
      .clk      (clk),
      .rst      (rst),
      .empty    (rxEmpty),
      .head     (rxHead),
      .pop      (rxPop),
      .rxCredit (rxCredit),
      .rxValid  (rxValid),
      .rxData   (rxData),
      .rxPare   (rxPare),
      .rxFrme   (rxFrme),
      .rxOvre   (rxOvre)
   );

   ////////////////////////////////////////////////////////////
   // Transmit path
   ////////////////////////////////////////////////////////////

   // Producer credits keep this from filling
   charFifo #(.T(txCharT), .DEPTH(TX_DEPTH)) txFifo_inst
   (
      .clk      (clk),
      .rst      (rst),
      .push     (txValid),
      .pushData (txData),
      .pop      (txPop),
      .head     (txHead),
      .empty    (txEmpty),
      .full     (),
      .credit   (txCredit)
   );

   uartTx uartTx_inst
   (
      .clk    (clk),
      .rst    (rst),
      .clr    (clr),
      .tick   (tick),
      .len    (len),
      .parity (parity),
      .stop   (stop),
      .empty  (txEmpty),
      .head   (txHead),
      .pop    (txPop),
      .txd    (txd)
   );

endmodule

// File: logic/rxCreditGate.sv
////////////////////////////////////////////////////////////
// Receive credit gate
//   Consumer credit counter, pops and registers entries
////////////////////////////////////////////////////////////

module rxCreditGate
   import uartPkg::*;
#(
   parameter int RX_CREDITS = 2
)
(
   input  logic    clk,
   input  logic    rst,
   input  logic    empty,
   input  rxEntryT head,
   output logic    pop,
   input  logic    rxCredit,
   output logic    rxValid,
   output txCharT  rxData,
   output logic    rxPare,
   output logic    rxFrme,
   output logic    rxOvre
);

   localparam int CW = $clog2(RX_CREDITS + 1);

   logic [CW-1:0] credits;

   // Deliver only with an entry waiting and credit left
   assign pop = !empty && (credits != '0);

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         credits <= CW'(RX_CREDITS);
         rxValid <= 1'b0;
         rxPare  <= 1'b0;
         rxFrme  <= 1'b0;
         rxOvre  <= 1'b0;
      end
      else
      begin
         rxValid <= pop;
         if (pop)
         begin
            rxPare <= head.pare;
            rxFrme <= head.frme;
            rxOvre <= head.ovre;
         end
         // Spend and return in one cycle cancel
         case ({pop, rxCredit})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   // Character payload
   always_ff @(posedge clk)
   begin
      if (pop)
         rxData <= head.data;
   end

endmodule

// File: logic/charFifo.sv
////////////////////////////////////////////////////////////
// Character FIFO
//   Circular buffer of any payload type
//   Registered credit pulse for every pop performed
////////////////////////////////////////////////////////////

module charFifo #(
   parameter type T     = logic [7:0],
   parameter int  DEPTH = 4
)
(
   input  logic clk,
   input  logic rst,
   input  logic push,
   input  T     pushData,
   input  logic pop,
   output T     head,
   output logic empty,
   output logic full,
   output logic credit
);

   localparam int PW   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNTW = $clog2(DEPTH + 1);

   T                mem [DEPTH];
   logic [PW-1:0]   wrPtr;
   logic [PW-1:0]   rdPtr;
   logic [CNTW-1:0] count;
   logic            doPush;
   logic            doPop;

   // Overflow and underflow requests are dropped
   assign doPush = push && !full;
   assign doPop  = pop && !empty;

   assign empty = (count == '0);
   assign full  = (count == CNTW'(DEPTH));
   assign head  = mem[rdPtr];

   // Storage
   always_ff @(posedge clk)
   begin
      if (doPush)
         mem[wrPtr] <= pushData;
   end

   ////////////////////////////////////////////////////////////
   // Pointers, occupancy and credit
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wrPtr  <= '0;
         rdPtr  <= '0;
         count  <= '0;
         credit <= 1'b0;
      end
      else
      begin
         credit <= doPop;
         // Pointers wrap at any depth
         if (doPush)
            wrPtr <= (wrPtr == PW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
         if (doPop)
            rdPtr <= (rdPtr == PW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
         case ({doPush, doPop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// File: logic/uartTx.sv
////////////////////////////////////////////////////////////
// UART transmitter
//   Pops the transmit FIFO and serializes one frame
//   Start bit, 5 to 8 data bits, optional parity, 1 or 2 stops
////////////////////////////////////////////////////////////

module uartTx
   import uartPkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  logic    clr,
   input  logic    tick,
   input  charLenT len,
   input  parityT  parity,
   input  stopT    stop,
   input  logic    empty,
   input  txCharT  head,
   output logic    pop,
   output logic    txd
);

   typedef enum logic [2:0]
   {
      stIdle,
      stLoad,
      stSync,
      stStart,
      stData,
      stParity,
      stStop1,
      stStop2
   } stateT;

   stateT      state;
   logic [3:0] brdiv;
   logic [2:0] bitCnt;
   txCharT     shReg;
   logic       parBit;
   txCharT     masked;
   logic       bitDone;

   // Bits above the length are ignored
   assign masked  = head & (8'hFF >> (2'd3 - len));
   assign bitDone = tick && (brdiv == 4'd0);

   // Pop in the load cycle
   assign pop = (state == stLoad);

   ////////////////////////////////////////////////////////////
   // Transmit FSM
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state  <= stIdle;
         brdiv  <= 4'd0;
         bitCnt <= 3'd0;
         shReg  <= '0;
         parBit <= 1'b0;
         txd    <= 1'b1;
      end
      else if (clr)
      begin
         state  <= stIdle;
         brdiv  <= 4'd0;
         bitCnt <= 3'd0;
         shReg  <= '0;
         parBit <= 1'b0;
         txd    <= 1'b1;
      end
      else
      begin
         case (state)
            stIdle:
               if (!empty)
                  state <= stLoad;
            // Take the head and its parity
            stLoad:
            begin
               shReg  <= masked;
               parBit <= (parity == parOdd) ? ~^masked : ^masked;
               state  <= stSync;
            end
            // Start bit begins on a tick boundary
            stSync:
               if (tick)
               begin
                  txd   <= 1'b0;
                  brdiv <= 4'd15;
                  state <= stStart;
               end
            stStart:
               if (bitDone)
               begin
                  txd    <= shReg[0];
                  shReg  <= shReg >> 1;
                  bitCnt <= 3'd0;
                  brdiv  <= 4'd15;
                  state  <= stData;
               end
               else if (tick)
                  brdiv <= brdiv - 1'b1;
            stData:
               if (bitDone)
               begin
                  brdiv <= 4'd15;
                  if (bitCnt == {1'b1, len})
                  begin
                     txd   <= parityOn(parity) ? parBit : 1'b1;
                     state <= parityOn(parity) ? stParity : stStop1;
                  end
                  else
                  begin
                     txd    <= shReg[0];
                     shReg  <= shReg >> 1;
                     bitCnt <= bitCnt + 1'b1;
                  end
               end
               else if (tick)
                  brdiv <= brdiv - 1'b1;
            stParity:
               if (bitDone)
               begin
                  txd   <= 1'b1;
                  brdiv <= 4'd15;
                  state <= stStop1;
               end
               else if (tick)
                  brdiv <= brdiv - 1'b1;
            // Line stays high through the stop bits
            stStop1:
               if (bitDone)
               begin
                  brdiv <= 4'd15;
                  state <= (stop == stop2) ? stStop2 : stIdle;
               end
               else if (tick)
                  brdiv <= brdiv - 1'b1;
            stStop2:
               if (bitDone)
                  state <= stIdle;
               else if (tick)
                  brdiv <= brdiv - 1'b1;
            default:
               state <= stIdle;
         endcase
      end
   end

endmodule

// File: logic/uartRx.sv
////////////////////////////////////////////////////////////
// UART receiver
//   Input synchronizer, start bit qualification, mid-bit sampling
//   Parity and framing checks, overrun tracking on push
////////////////////////////////////////////////////////////

module uartRx
   import uartPkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  logic    clr,
   input  logic    tick,
   input  logic    rxd,
   input  charLenT len,
   input  parityT  parity,
   input  stopT    stop,
   input  logic    bufFull,
   output logic    push,
   output rxEntryT entry
);

   typedef enum logic [2:0]
   {
      stIdle,
      stStart,
      stData,
      stParity,
      stStop1,
      stStop2,
      stWait,
      stDone
   } stateT;

   stateT            state;
   logic             rxMeta;
   logic             rxSync;
   logic [3:0]       brdiv;
   logic [2:0]       bitCnt;
   logic [dataW-1:0] shReg;
   logic             pare;
   logic             frme;
   logic             ovrPend;
   logic             bitDone;
   logic             expPar;

   ////////////////////////////////////////////////////////////
   // Synchronizer
   ////////////////////////////////////////////////////////////

   // Line idles high
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rxMeta <= 1'b1;
         rxSync <= 1'b1;
      end
      else
      begin
         rxMeta <= rxd;
         rxSync <= rxMeta;
      end
   end

   // End of a 16 tick bit time
   assign bitDone = tick && (brdiv == 4'd0);

   // Expected parity bit, zero fill does not disturb it
   assign expPar = (parity == parOdd) ? ~^shReg : ^shReg;

   ////////////////////////////////////////////////////////////
   // Receive FSM
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state   <= stIdle;
         brdiv   <= 4'd0;
         bitCnt  <= 3'd0;
         shReg   <= '0;
         pare    <= 1'b0;
         frme    <= 1'b0;
         ovrPend <= 1'b0;
      end
      else if (clr)
      begin
         state   <= stIdle;
         brdiv   <= 4'd0;
         bitCnt  <= 3'd0;
         shReg   <= '0;
         pare    <= 1'b0;
         frme    <= 1'b0;
         ovrPend <= 1'b0;
      end
      else
      begin
         case (state)
            // Falling edge of a start bit
            stIdle:
               if (tick && !rxSync)
               begin
                  brdiv <= 4'd7;
                  state <= stStart;
               end
            // Start bit must stay low up to its middle
            stStart:
               if (tick)
               begin
                  if (rxSync)
                     state <= stIdle;
                  else if (brdiv == 4'd0)
                  begin
                     brdiv  <= 4'd15;
                     bitCnt <= 3'd0;
                     shReg  <= '0;
                     pare   <= 1'b0;
                     frme   <= 1'b0;
                     state  <= stData;
                  end
                  else
                     brdiv <= brdiv - 1'b1;
               end
            // Data bits, LSB first into the top
            stData:
               if (bitDone)
               begin
                  brdiv  <= 4'd15;
                  shReg  <= {rxSync, shReg[dataW-1:1]};
                  bitCnt <= bitCnt + 1'b1;
                  // Last index is 4 plus the length code
                  if (bitCnt == {1'b1, len})
                     state <= parityOn(parity) ? stParity : stStop1;
               end
               else if (tick)
                  brdiv <= brdiv - 1'b1;
            stParity:
               if (bitDone)
               begin
                  pare  <= (rxSync != expPar);
                  brdiv <= 4'd15;
                  state <= stStop1;
               end
               else if (tick)
                  brdiv <= brdiv - 1'b1;
            // Low stop bit is a framing error
            stStop1:
               if (bitDone)
               begin
                  if (!rxSync)
                     frme <= 1'b1;
                  if (stop == stop2)
                  begin
                     brdiv <= 4'd15;
                     state <= stStop2;
                  end
                  else
                  begin
                     brdiv <= 4'd7;
                     state <= stWait;
                  end
               end
               else if (tick)
                  brdiv <= brdiv - 1'b1;
            stStop2:
               if (bitDone)
               begin
                  if (!rxSync)
                     frme <= 1'b1;
                  brdiv <= 4'd7;
                  state <= stWait;
               end
               else if (tick)
                  brdiv <= brdiv - 1'b1;
            // Half a bit to the end of the stop bit
            stWait:
               if (bitDone)
                  state <= stDone;
               else if (tick)
                  brdiv <= brdiv - 1'b1;
            // Drop on a full buffer and remember the loss
            stDone:
            begin
               ovrPend <= bufFull;
               state   <= stIdle;
            end
            default:
               state <= stIdle;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Entry and push
   ////////////////////////////////////////////////////////////

   assign push = (state == stDone) && !bufFull;

   // Short characters shift down to bit 0
   assign entry.data = shReg >> (2'd3 - len);
   assign entry.pare = pare;
   assign entry.frme = frme;
   assign entry.ovre = ovrPend;

endmodule

// File: logic/baudGen.sv
////////////////////////////////////////////////////////////
// Baud generator
//   One-cycle tick at 16 times the bit rate
////////////////////////////////////////////////////////////

module baudGen #(
   parameter int CLKS_PER_TICK = 4
)
(
   input  logic clk,
   input  logic rst,
   output logic tick
);

   // Counter wide enough for a divisor of one
   localparam int CW = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;

   logic [CW-1:0] cnt;

   // Wrap and pulse
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         cnt  <= '0;
         tick <= 1'b0;
      end
      else if (cnt == CW'(CLKS_PER_TICK - 1))
      begin
         cnt  <= '0;
         tick <= 1'b1;
      end
      else
      begin
         cnt  <= cnt + 1'b1;
         tick <= 1'b0;
      end
   end

endmodule

// File: logic/uartPkg.sv
////////////////////////////////////////////////////////////
// UART shared definitions
//   Character format codes, receive entry layout and widths
//   Parity enable helper used by both serial engines
////////////////////////////////////////////////////////////

package uartPkg;

   // Widest character
   localparam int dataW = 8;

   // Character length codes
   typedef enum logic [1:0]
   {
      len5 = 2'd0,
      len6 = 2'd1,
      len7 = 2'd2,
      len8 = 2'd3
   } charLenT;

   // Parity codes, the spare code behaves as none
   typedef enum logic [1:0]
   {
      parNone  = 2'd0,
      parEven  = 2'd1,
      parOdd   = 2'd2,
      parSpare = 2'd3
   } parityT;

   // Stop bit count
   typedef enum logic
   {
      stop1 = 1'b0,
      stop2 = 1'b1
   } stopT;

   // Transmit character
   typedef logic [dataW-1:0] txCharT;

   // Receive FIFO entry, data right-aligned
   typedef struct packed
   {
      logic [dataW-1:0] data;
      logic             pare;
      logic             frme;
      logic             ovre;
   } rxEntryT;

   // True when a parity bit is part of the frame
   function automatic logic parityOn(parityT p);
      return (p == parEven) || (p == parOdd);
   endfunction

endpackage
